//--- mem_model.f
src/mem_model_pkg.sv
src/lfsr_fill_source.sv
src/lsu_request_align.sv
src/mem_rw_helper.sv
src/load_data_extract.sv
src/mem_model_top.sv
tb/mem_model_properties.sv
tb/mem_model_tb.sv

//--- src/lfsr_fill_source.sv
`timescale 1ns/10ps
`default_nettype none

module lfsr_fill_source (
  input  wire                                  glb_clk,
  input  wire                                  reset,
  output logic [mem_model_pkg::data_width-1:0] fill_value
);
  import mem_model_pkg::*;

  logic [data_width-1:0] next_value;
  logic [data_width-1:0] feedback;

  // shift right, fold the taps back in when a one falls out
  assign feedback   = fill_value[0] ? lfsr_taps : '0;
  assign next_value = (fill_value >> 1) ^ feedback;

  // free running, one step per clock
  always_ff @(posedge glb_clk) begin
    if (reset) begin
      fill_value <= fill_seed;
    end else begin
      fill_value <= next_value;
    end
  end

endmodule

`default_nettype wire

//--- src/load_data_extract.sv
`timescale 1ns/10ps
`default_nettype none

module load_data_extract (
  input  wire                                  glb_clk,
  input  wire                                  reset,
  input  wire                                  r_enable,
  input  wire mem_model_pkg::load_tag_t        access_tag,
  input  wire [mem_model_pkg::data_width-1:0]  r_data,
  output logic                                 rsp_valid,
  output logic [mem_model_pkg::data_width-1:0] rsp_data
);
  import mem_model_pkg::*;

  load_tag_t             tag_q;       // load in flight
  logic [data_width-1:0] lane_data;
  logic                  sign;

  always_ff @(posedge glb_clk) begin
    if (reset) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= r_enable;
    end
  end

  always_ff @(posedge glb_clk) begin
    if (r_enable) begin
      tag_q <= access_tag;
    end
  end

  // addressed byte down to lane 0
  assign lane_data = r_data >> {tag_q.offset, 3'b000};
  assign sign      = tag_q.sign_ext;

  always_comb begin
    unique case (tag_q.size)
      size_byte:  rsp_data = {{56{sign & lane_data[7]}}, lane_data[7:0]};
      size_half:  rsp_data = {{48{sign & lane_data[15]}}, lane_data[15:0]};
      size_word:  rsp_data = {{32{sign & lane_data[31]}}, lane_data[31:0]};
      size_dword: rsp_data = lane_data;   // offset is zero here
    endcase
  end

endmodule

`default_nettype wire

//--- src/lsu_request_align.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_request_align (
  input  wire mem_model_pkg::mem_req_t    req,
  output mem_model_pkg::word_access_t     access
);
  import mem_model_pkg::*;

  logic [2:0]            offset;
  logic [7:0]            size_lanes;   // lanes before the offset shift
  logic [7:0]            byte_lanes;
  logic [data_width-1:0] size_data;
  logic [5:0]            bit_shift;

  assign offset    = req.addr[2:0];
  assign bit_shift = {offset, 3'b000};

  // keep only the bytes the size covers
  always_comb begin
    unique case (req.size)
      size_byte: begin
        size_lanes = 8'h01;
        size_data  = {56'b0, req.wdata[7:0]};
      end
      size_half: begin
        size_lanes = 8'h03;
        size_data  = {48'b0, req.wdata[15:0]};
      end
      size_word: begin
        size_lanes = 8'h0f;
        size_data  = {32'b0, req.wdata[31:0]};
      end
      size_dword: begin
        size_lanes = 8'hff;
        size_data  = req.wdata;
      end
    endcase
  end

  // natural alignment assumed, so nothing spills past lane 7
  assign byte_lanes = size_lanes << offset;

  always_comb begin
    access.index = req.addr[addr_width-1:3];
    access.data  = size_data << bit_shift;
    for (int b = 0; b < 8; b++) begin
      access.mask[b*8 +: 8] = {8{byte_lanes[b]}};   // widen lane bit to byte
    end
  end

endmodule

`default_nettype wire

//--- src/mem_model_pkg.sv
`default_nettype none

package mem_model_pkg;

  localparam int data_width     = 64;
  localparam int ram_items      = 2 ** 28;             // 2 GiB of bytes in 8-byte words
  localparam int index_width    = $clog2(ram_items);
  localparam int addr_width     = index_width + 3;     // byte address
  localparam int cache_lines    = 16;
  localparam int line_sel_width = $clog2(cache_lines);

  // galois taps for x^64 + x^63 + x^61 + x^60 + 1
  localparam logic [data_width-1:0] lfsr_taps = 64'hd800_0000_0000_0000;
  localparam logic [data_width-1:0] fill_seed = 64'h9e37_79b9_7f4a_7c15;

  typedef enum logic [1:0] {
    size_byte  = 2'd0,
    size_half  = 2'd1,
    size_word  = 2'd2,
    size_dword = 2'd3
  } access_size_t;

  // request as seen at the top
  typedef struct packed {
    logic                  write;
    logic [addr_width-1:0] addr;
    access_size_t          size;
    logic                  sign_ext;
    logic [data_width-1:0] wdata;
  } mem_req_t;

  // one word-wide access after alignment
  typedef struct packed {
    logic [index_width-1:0] index;
    logic [data_width-1:0]  mask;   // one bit per data bit, set per byte
    logic [data_width-1:0]  data;   // already in its byte lanes
  } word_access_t;

  typedef struct packed {
    logic [2:0]   offset;
    access_size_t size;
    logic         sign_ext;
  } load_tag_t;

endpackage

`default_nettype wire

//--- src/mem_model_top.sv
`timescale 1ns/10ps
`default_nettype none

module mem_model_top (
  input  wire                                 glb_clk,
  input  wire                                 reset,
  input  wire                                 req_valid,
  input  wire mem_model_pkg::mem_req_t        req,
  output wire                                 rsp_valid,
  output wire [mem_model_pkg::data_width-1:0] rsp_data
);
  import mem_model_pkg::*;

  word_access_t          access;
  load_tag_t             load_tag;
  logic                  r_enable;
  logic                  w_enable;
  logic [data_width-1:0] fill_value;
  logic [data_width-1:0] r_data;

  // plain strobe, no handshake
  assign r_enable = req_valid && !req.write;
  assign w_enable = req_valid && req.write;

  assign load_tag = '{offset: req.addr[2:0], size: req.size, sign_ext: req.sign_ext};

  lsu_request_align u_align (
    .req    (req),
    .access (access)
  );

  lfsr_fill_source u_fill (
    .glb_clk    (glb_clk),
    .reset      (reset),
    .fill_value (fill_value)
  );

  mem_rw_helper u_store (
    .glb_clk    (glb_clk),
    .reset      (reset),
    .r_enable   (r_enable),
    .w_enable   (w_enable),
    .access     (access),
    .fill_value (fill_value),
    .r_data     (r_data)
  );

  load_data_extract u_extract (
    .glb_clk    (glb_clk),
    .reset      (reset),
    .r_enable   (r_enable),
    .access_tag (load_tag),
    .r_data     (r_data),
    .rsp_valid  (rsp_valid),
    .rsp_data   (rsp_data)
  );

endmodule

`default_nettype wire

//--- src/mem_rw_helper.sv
`timescale 1ns/10ps
`default_nettype none

module mem_rw_helper (
  input  wire                                  glb_clk,
  input  wire                                  reset,
  input  wire                                  r_enable,
  input  wire                                  w_enable,
  input  wire mem_model_pkg::word_access_t     access,
  input  wire [mem_model_pkg::data_width-1:0]  fill_value,
  output logic [mem_model_pkg::data_width-1:0] r_data
);
  import mem_model_pkg::*;

  logic [cache_lines-1:0]    line_valid;
  logic [index_width-1:0]    line_tag  [cache_lines];
  logic [data_width-1:0]     line_data [cache_lines];
  logic [line_sel_width-1:0] fill_ptr;        // next line to replace on a miss

  logic [cache_lines-1:0]    line_hit;
  logic                      hit;
  logic [line_sel_width-1:0] hit_line;
  logic [data_width-1:0]     hit_word;
  logic [data_width-1:0]     merge_base;
  logic [data_width-1:0]     merged_word;
  logic [line_sel_width-1:0] target_line;

  // all tags compared at once
  always_comb begin
    for (int i = 0; i < cache_lines; i++) begin
      line_hit[i] = line_valid[i] && (line_tag[i] == access.index);
    end
  end

  assign hit = |line_hit;

  // lowest matching line wins
  always_comb begin
    hit_line = '0;
    for (int i = cache_lines - 1; i >= 0; i--) begin
      if (line_hit[i]) begin
        hit_line = line_sel_width'(i);
      end
    end
  end

  assign hit_word    = line_data[hit_line];
  assign merge_base  = hit ? hit_word : fill_value;   // unwritten bytes are arbitrary
  assign merged_word = (access.data & access.mask) | (merge_base & ~access.mask);
  assign target_line = hit ? hit_line : fill_ptr;

  // line contents and read port
  always_ff @(posedge glb_clk) begin
    if (r_enable) begin
      r_data <= hit ? hit_word : fill_value;
      if (!hit) begin
        line_tag[fill_ptr]  <= access.index;
        line_data[fill_ptr] <= fill_value;   // remember what was returned
      end
    end
    // a write in the same cycle overrides the read fill
    if (w_enable) begin
      line_tag[target_line]  <= access.index;
      line_data[target_line] <= merged_word;
    end
  end

  // valid bits and replacement pointer
  always_ff @(posedge glb_clk) begin
    if (reset) begin
      line_valid <= '0;
      fill_ptr   <= '0;
    end else if (r_enable || w_enable) begin
      if (!hit) begin
        line_valid[fill_ptr] <= 1'b1;
      end
      fill_ptr <= fill_ptr + 1'b1;   // moves on hits too, wraps at 16
    end
  end

endmodule

`default_nettype wire

//--- tb/mem_model_patterns.txt
# op addr size sign wdata expect mode name
# size 0..3 = byte, half, word, dword; mode exact, consistent or skip; stores compare nothing
# full doublewords, up to the largest index
st 00000000 3 0 1122334455667788 0000000000000000 skip dw_st_idx0
ld 00000000 3 0 0000000000000000 1122334455667788 exact dw_ld_idx0
st 00001238 3 0 a5a50f0f5a5af0f0 0000000000000000 skip dw_st_idx247
ld 00001238 3 0 0000000000000000 a5a50f0f5a5af0f0 exact dw_ld_idx247
st 7ffffff8 3 0 deadbeefcafef00d 0000000000000000 skip dw_st_top
ld 7ffffff8 3 0 0000000000000000 deadbeefcafef00d exact dw_ld_top
# bytes at every offset
st 00000100 0 0 ffffffffffffff81 0000000000000000 skip b0_st
ld 00000100 0 1 0000000000000000 ffffffffffffff81 exact b0_ld
st 00000101 0 0 000000000000007e 0000000000000000 skip b1_st
ld 00000101 0 1 0000000000000000 000000000000007e exact b1_ld
st 00000102 0 0 55555555555555c3 0000000000000000 skip b2_st
ld 00000102 0 0 0000000000000000 00000000000000c3 exact b2_ld
st 00000103 0 0 0000000000000080 0000000000000000 skip b3_st
ld 00000103 0 1 0000000000000000 ffffffffffffff80 exact b3_ld
st 00000104 0 0 0000000000000012 0000000000000000 skip b4_st
ld 00000104 0 0 0000000000000000 0000000000000012 exact b4_ld
st 00000105 0 0 00000000000000fe 0000000000000000 skip b5_st
ld 00000105 0 1 0000000000000000 fffffffffffffffe exact b5_ld
st 00000106 0 0 00000000000000a0 0000000000000000 skip b6_st
ld 00000106 0 0 0000000000000000 00000000000000a0 exact b6_ld
st 00000107 0 0 123456789abcde9c 0000000000000000 skip b7_st
ld 00000107 0 1 0000000000000000 ffffffffffffff9c exact b7_ld
# halves and words
st 00000108 1 0 0000000000008001 0000000000000000 skip h0_st
ld 00000108 1 1 0000000000000000 ffffffffffff8001 exact h0_ld
st 0000010a 1 0 ffffffffffff7fff 0000000000000000 skip h2_st
ld 0000010a 1 1 0000000000000000 0000000000007fff exact h2_ld
st 0000010c 1 0 000000000000beef 0000000000000000 skip h4_st
ld 0000010c 1 0 0000000000000000 000000000000beef exact h4_ld
st 0000010e 1 0 000000000000f00d 0000000000000000 skip h6_st
ld 0000010e 1 1 0000000000000000 fffffffffffff00d exact h6_ld
st 00000110 2 0 0000000089abcdef 0000000000000000 skip w0_st
ld 00000110 2 1 0000000000000000 ffffffff89abcdef exact w0_ld
st 00000114 2 0 aaaaaaaafedcba98 0000000000000000 skip w4_st
ld 00000114 2 0 0000000000000000 00000000fedcba98 exact w4_ld
# never written word read again and again
ld 00002000 3 0 0000000000000000 0000000000000000 consistent fresh_first
ld 00002000 3 0 0000000000000000 0000000000000000 consistent fresh_again
ld 00002004 2 0 0000000000000000 0000000000000000 consistent fresh_upper
ld 00002000 3 0 0000000000000000 0000000000000000 consistent fresh_third
# partial stores into an observed word
ld 00002008 3 0 0000000000000000 0000000000000000 consistent part_first
st 0000200a 1 0 0000000000005a5a 0000000000000000 skip part_st_half
st 0000200f 0 0 000000000000003c 0000000000000000 skip part_st_byte
ld 00002008 3 0 0000000000000000 0000000000000000 consistent part_merged
# misses walk the pointer round until fresh_first's line is replaced
ld 00003000 3 0 0000000000000000 0000000000000000 consistent evict_fill0
ld 00003008 3 0 0000000000000000 0000000000000000 consistent evict_fill1
ld 00003010 3 0 0000000000000000 0000000000000000 consistent evict_fill2
ld 00002008 3 0 0000000000000000 0000000000000000 consistent part_in_window
ld 00003018 3 0 0000000000000000 0000000000000000 consistent evict_fill3
ld 00003020 3 0 0000000000000000 0000000000000000 consistent evict_fill4
ld 00003028 3 0 0000000000000000 0000000000000000 consistent evict_fill5
ld 00003030 3 0 0000000000000000 0000000000000000 consistent evict_fill6
ld 00003038 3 0 0000000000000000 0000000000000000 consistent evict_fill7
ld 00002000 3 0 0000000000000000 0000000000000000 skip fresh_forgotten
ld 00002000 3 0 0000000000000000 0000000000000000 consistent fresh_relearned
ld 00002008 3 0 0000000000000000 0000000000000000 consistent part_still_held
ld 7ffffff8 3 0 0000000000000000 deadbeefcafef00d exact dw_top_held

//--- tb/mem_model_properties.sv
`timescale 1ns/10ps
`default_nettype none

module mem_model_properties (
  input wire                          glb_clk,
  input wire                          reset,
  input wire                          req_valid,
  input wire mem_model_pkg::mem_req_t req,
  input wire                          rsp_valid
);
  import mem_model_pkg::*;

  logic       is_load;
  logic       is_store;
  logic [2:0] align_mask;   // offset bits that must be zero for the size

  assign is_load  = req_valid && !req.write;
  assign is_store = req_valid && req.write;

  always_comb begin
    case (req.size)
      size_byte: align_mask = 3'b000;
      size_half: align_mask = 3'b001;
      size_word: align_mask = 3'b011;
      default:   align_mask = 3'b111;
    endcase
  end

  // every load answers in the next cycle
  load_gets_response: assert property (
    @(posedge glb_clk) disable iff (reset) is_load |=> rsp_valid
  ) else $error("load not answered in the next cycle");

  // and nothing else produces a response
  response_needs_load: assert property (
    @(posedge glb_clk) disable iff (reset) rsp_valid |-> $past(is_load)
  ) else $error("response without a load one cycle earlier");

  quiet_in_reset: assert property (
    @(posedge glb_clk) reset |=> !rsp_valid
  ) else $error("response pulse while reset is high");

  store_aligned: assert property (
    @(posedge glb_clk) disable iff (reset)
      is_store |-> ((req.addr[2:0] & align_mask) == 3'b000)
  ) else $error("store not naturally aligned");

endmodule

`default_nettype wire

//--- tb/mem_model_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mem_model_tb;
  import mem_model_pkg::*;

  localparam int rsp_timeout = 20;   // cycles

  logic                 glb_clk;
  logic                 reset;
  logic                 req_valid;
  mem_req_t             req;
  wire                  rsp_valid;
  wire [data_width-1:0] rsp_data;

  // shadow of the sixteen remembered words
  logic                   sh_valid [cache_lines];
  logic [index_width-1:0] sh_tag   [cache_lines];
  logic [7:0]             sh_byte  [cache_lines][8];
  logic [7:0]             sh_known [cache_lines];   // one bit per byte lane
  int                     sh_ptr;

  int errors;
  int checks;
  int loads_sent;
  int rsp_seen;

  mem_model_top UUT (
    .glb_clk   (glb_clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp_data  (rsp_data)
  );

  bind mem_model_top mem_model_properties u_props (
    .glb_clk   (glb_clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req       (req),
    .rsp_valid (rsp_valid)
  );

  always #4 glb_clk = ~glb_clk;

  always @(negedge glb_clk) begin
    if (!reset && rsp_valid) begin
      rsp_seen++;   // each cycle of a pulse counts
    end
  end

  // low nbytes bytes widened by the load's extension rule
  function automatic logic [63:0] extend_load(input logic [63:0] raw, input int nbytes,
                                              input logic sgn);
    logic [63:0] result;
    logic        top_bit;
    top_bit = raw[nbytes*8-1];
    for (int i = 0; i < 64; i++) begin
      result[i] = (i < nbytes * 8) ? raw[i] : (sgn & top_bit);
    end
    return result;
  endfunction

  // hit keeps its line, a miss takes the pointer's line with nothing known
  function automatic int shadow_touch(input logic [index_width-1:0] index);
    int line;
    line = -1;
    for (int i = cache_lines - 1; i >= 0; i--) begin
      if (sh_valid[i] && sh_tag[i] == index) begin
        line = i;
      end
    end
    if (line < 0) begin
      line           = sh_ptr;
      sh_valid[line] = 1'b1;
      sh_tag[line]   = index;
      sh_known[line] = '0;
    end
    sh_ptr = (sh_ptr + 1) % cache_lines;   // moves on every request
    return line;
  endfunction

  task automatic run_line(input logic is_store, input logic [addr_width-1:0] addr,
                          input int size, input logic sgn, input logic [63:0] wdata,
                          input logic [63:0] expect_v, input logic [95:0] mode,
                          input logic [191:0] name);
    logic [2:0]  offset;
    int          nbytes;
    int          line;
    int          waited;
    logic        fresh;
    logic [63:0] raw;
    logic [63:0] expected;
    offset = addr[2:0];
    nbytes = 1 << size;
    line   = shadow_touch(addr[addr_width-1:3]);

    @(posedge glb_clk);
    req_valid    <= 1'b1;
    req.write    <= is_store;
    req.addr     <= addr;
    req.size     <= access_size_t'(size);
    req.sign_ext <= sgn;
    req.wdata    <= wdata;
    @(posedge glb_clk);
    req_valid <= 1'b0;

    if (is_store) begin
      for (int k = 0; k < nbytes; k++) begin
        sh_byte[line][offset + k]  = wdata[k*8 +: 8];
        sh_known[line][offset + k] = 1'b1;
      end
    end else begin
      loads_sent++;
      waited = 0;
      do begin
        @(negedge glb_clk);
        waited++;
      end while (!rsp_valid && waited < rsp_timeout);
      if (!rsp_valid) begin
        $display("load %0s got no response within %0d cycles", name, rsp_timeout);
        errors++;
      end else begin
        if (waited != 1) begin
          $display("load %0s was answered after %0d cycles instead of 1", name, waited);
          errors++;
        end
        // unknown lanes are learned from this response
        raw   = '0;
        fresh = 1'b1;
        for (int k = 0; k < nbytes; k++) begin
          if (!sh_known[line][offset + k]) begin
            sh_byte[line][offset + k]  = rsp_data[k*8 +: 8];
            sh_known[line][offset + k] = 1'b1;
          end else begin
            fresh = 1'b0;
          end
          raw[k*8 +: 8] = sh_byte[line][offset + k];
        end
        expected = (mode == "exact") ? expect_v : extend_load(raw, nbytes, sgn);
        // a full word seen for the first time has nothing to compare against
        if (mode == "exact" || (mode == "consistent" && (!fresh || nbytes < 8))) begin
          checks++;
          if (rsp_data !== expected) begin
            $display("FAIL %0s: expected %h, got %h", name, expected, rsp_data);
            errors++;
          end
        end
      end
    end
  endtask

  initial begin
    int                    fd;
    int                    code;
    int                    gap;
    int                    size_v;
    int                    sign_v;
    logic [63:0]           op_tok;
    logic [95:0]           mode_tok;
    logic [191:0]          name_tok;
    logic [1023:0]         skip_line;
    logic [addr_width-1:0] addr_v;
    logic [63:0]           wdata_v;
    logic [63:0]           expect_v;
    glb_clk    = 1'b0;
    reset      = 1'b1;
    req_valid  = 1'b0;
    req        = '0;
    errors     = 0;
    checks     = 0;
    loads_sent = 0;
    rsp_seen   = 0;
    sh_ptr     = 0;
    for (int i = 0; i < cache_lines; i++) begin
      sh_valid[i] = 1'b0;
      sh_known[i] = '0;
    end
    gap = $urandom(32'hce31);   // seeds the idle gaps
    repeat (4) @(posedge glb_clk);
    reset <= 1'b0;

    fd = $fopen("tb/mem_model_patterns.txt", "r");
    if (fd == 0) begin
      $display("pattern file tb/mem_model_patterns.txt could not be opened");
      errors++;
    end else begin
      while ($fscanf(fd, "%s", op_tok) == 1) begin
        if (op_tok == "#") begin
          code = $fgets(skip_line, fd);   // rest of a comment line
        end else begin
          code = $fscanf(fd, "%h %d %d %h %h %s %s", addr_v, size_v, sign_v, wdata_v,
                         expect_v, mode_tok, name_tok);
          if (code != 7) begin
            $display("pattern line after %0d loads is malformed", loads_sent);
            errors++;
            break;
          end
          run_line(op_tok == "st", addr_v, size_v, sign_v[0], wdata_v, expect_v,
                   mode_tok, name_tok);
          gap = $urandom % 3;
          repeat (gap) @(posedge glb_clk);
        end
      end
      $fclose(fd);
    end

    repeat (4) @(posedge glb_clk);
    checks++;
    if (rsp_seen != loads_sent) begin
      $display("%0d response cycles seen for %0d loads", rsp_seen, loads_sent);
      errors++;
    end
    $display("errors %0d, checks %0d", errors, checks);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
